/* hw/calc_pkg.sv */
package calc_pkg;

    // key banks
    localparam int NUM_DIGIT_KEYS = 10;
    localparam int NUM_OP_KEYS    = 5;

    // datapath sizes
    localparam int WORD_W     = 32;
    localparam int BCD_DIGITS = 10;

    typedef logic [3:0] digit_t;

    // order matches the operator key index
    typedef enum logic [2:0]
    {
        OP_ADD,
        OP_SUB,
        OP_MUL,
        OP_DIV,
        OP_EQU
    } op_t;

    // two's complement, wraps on overflow
    typedef logic signed [WORD_W-1:0] word_t;

    // most significant digit in the top nibble
    typedef logic [4*BCD_DIGITS-1:0] bcd_t;

    // segments a..g then dot in bit 0
    typedef logic [7:0] seg_t;

    typedef logic [NUM_OP_KEYS-1:0] led_t;

    // segment codes for digits 0..9
    localparam seg_t SEG_TABLE [NUM_DIGIT_KEYS] = '{
        8'hFC,
        8'h60,
        8'hDA,
        8'hF2,
        8'h66,
        8'hB6,
        8'hBE,
        8'hE0,
        8'hFE,
        8'hF6
    };

endpackage

/* hw/key_capture.sv */
`timescale 1ns/1ps

module key_capture
    import calc_pkg::*;
#(
    parameter type code_t = digit_t
)
(
    input  logic  rst,
    input  logic  clk_100hz,
    input  logic  pressed,
    input  code_t code,
    output logic  strobe,
    output code_t held
);

    logic pressed_q;
    logic press_edge;

    // first high sample after a low one
    assign press_edge = pressed & ~pressed_q;

    always_ff @(posedge rst or posedge clk_100hz)
    begin
        if (clk_100hz)
        begin
            pressed_q <= 1'b0;
            strobe    <= 1'b0;
        end
        else
        begin
            pressed_q <= pressed;
            strobe    <= press_edge;
        end
    end

    always_ff @(posedge rst)
    begin
        if (press_edge)
            held <= code;
    end

endmodule

/* hw/bin_to_bcd.sv */
`timescale 1ns/1ps

module bin_to_bcd
    import calc_pkg::*;
(
    input  logic  rst,
    input  logic  clk_100hz,
    input  logic  start,
    input  word_t magnitude,
    output bcd_t  bcd,
    output logic  done
);

    logic                      busy;
    logic [$clog2(WORD_W)-1:0] bit_cnt;
    logic [WORD_W-1:0]         bin_sr;
    logic [WORD_W-1:0]         bin_nxt;
    bcd_t                      bcd_sr;
    bcd_t                      bcd_adj;
    bcd_t                      bcd_nxt;

    // add 3 to every digit of 5 or more, then shift one bit in
    always_comb
    begin
        bcd_adj = bcd_sr;
        for (int i = 0; i < BCD_DIGITS; i++)
        begin
            if (bcd_adj[4*i +: 4] >= 4'd5)
                bcd_adj[4*i +: 4] = bcd_adj[4*i +: 4] + 4'd3;
        end
        {bcd_nxt, bin_nxt} = {bcd_adj, bin_sr} << 1;
    end

    always_ff @(posedge rst or posedge clk_100hz)
    begin
        if (clk_100hz)
        begin
            busy    <= 1'b0;
            bit_cnt <= '0;
            done    <= 1'b0;
            bcd     <= '0;
        end
        else
        begin
            done <= 1'b0;
            if (busy)
            begin
                bit_cnt <= bit_cnt + ($clog2(WORD_W))'(1);
                if (bit_cnt == ($clog2(WORD_W))'(WORD_W - 1))
                begin
                    busy <= 1'b0;
                    done <= 1'b1;
                    bcd  <= bcd_nxt;
                end
            end
            else if (start)
            begin
                busy    <= 1'b1;
                bit_cnt <= '0;
            end
        end
    end

    // a start while busy is dropped
    always_ff @(posedge rst)
    begin
        if (!busy && start)
        begin
            bin_sr <= magnitude;
            bcd_sr <= '0;
        end
        else if (busy)
        begin
            bin_sr <= bin_nxt;
            bcd_sr <= bcd_nxt;
        end
    end

endmodule

/* hw/digit_entry.sv */
`timescale 1ns/1ps

module digit_entry
    import calc_pkg::*;
(
    input  logic                      rst,
    input  logic                      clk_100hz,
    input  logic [NUM_DIGIT_KEYS-1:0] key_digit,
    output logic                      digit_strobe,
    output digit_t                    digit_val,
    output seg_t                      seg
);

    logic   any_digit;
    digit_t digit_code;
    logic   digit_seen;

    assign any_digit = |key_digit;

    // keys 1..9 win over 0, lower number first
    always_comb
    begin
        digit_code = '0;
        for (int i = NUM_DIGIT_KEYS - 1; i > 0; i--)
        begin
            if (key_digit[i])
                digit_code = digit_t'(i);
        end
    end

    key_capture #(
        .code_t (digit_t)
    ) digit_cap_i (
        .rst       (rst),
        .clk_100hz (clk_100hz),
        .pressed   (any_digit),
        .code      (digit_code),
        .strobe    (digit_strobe),
        .held      (digit_val)
    );

    always_ff @(posedge rst or posedge clk_100hz)
    begin
        if (clk_100hz)
            digit_seen <= 1'b0;
        else if (digit_strobe)
            digit_seen <= 1'b1;
    end

    // blank until the first digit arrives
    assign seg = (digit_seen | digit_strobe) ? SEG_TABLE[digit_val] : '0;

endmodule

/* hw/operator_entry.sv */
`timescale 1ns/1ps

module operator_entry
    import calc_pkg::*;
(
    input  logic                   rst,
    input  logic                   clk_100hz,
    input  logic [NUM_OP_KEYS-1:0] key_op,
    output logic                   op_strobe,
    output op_t                    op_val,
    output led_t                   led
);

    logic any_op;
    op_t  op_code;
    logic op_seen;

    assign any_op = |key_op;

    // lowest index wins
    always_comb
    begin
        op_code = OP_ADD;
        for (int i = NUM_OP_KEYS - 1; i >= 0; i--)
        begin
            if (key_op[i])
                op_code = op_t'(i);
        end
    end

    key_capture #(
        .code_t (op_t)
    ) op_cap_i (
        .rst       (rst),
        .clk_100hz (clk_100hz),
        .pressed   (any_op),
        .code      (op_code),
        .strobe    (op_strobe),
        .held      (op_val)
    );

    always_ff @(posedge rst or posedge clk_100hz)
    begin
        if (clk_100hz)
            op_seen <= 1'b0;
        else if (op_strobe)
            op_seen <= 1'b1;
    end

    assign led = (op_seen | op_strobe) ? (led_t'(1) << op_val) : '0;

endmodule

/* hw/calc_core.sv */
`timescale 1ns/1ps

module calc_core
    import calc_pkg::*;
(
    input  logic   rst,
    input  logic   clk_100hz,
    input  logic   digit_strobe,
    input  digit_t digit_val,
    input  logic   op_strobe,
    input  op_t    op_val,
    output bcd_t   result_bcd,
    output logic   result_neg,
    output logic   result_valid
);

    word_t term;
    word_t acc;
    word_t alu_res;
    word_t mag_q;
    op_t   pend_op;
    logic  neg_q;
    logic  neg_run;
    logic  neg_hold;
    logic  start;
    logic  conv_busy;
    logic  conv_accept;

    // apply the pending operator to acc and term
    always_comb
    begin
        case (pend_op)
            OP_ADD:  alu_res = acc + term;
            OP_SUB:  alu_res = acc - term;
            OP_MUL:  alu_res = acc * term;
            OP_DIV:
            begin
                if (term == 0)
                    alu_res = '0;
                else
                    alu_res = acc / term;
            end
            default: alu_res = term;
        endcase
    end

    // operator strobe takes precedence over a digit
    always_ff @(posedge rst or posedge clk_100hz)
    begin
        if (clk_100hz)
        begin
            term    <= '0;
            acc     <= '0;
            pend_op <= OP_ADD;
            start   <= 1'b0;
        end
        else
        begin
            start <= 1'b0;
            if (op_strobe)
            begin
                term <= '0;
                if (op_val == OP_EQU)
                begin
                    acc     <= '0;
                    pend_op <= OP_ADD;
                    start   <= 1'b1;
                end
                else
                begin
                    acc     <= alu_res;
                    pend_op <= op_val;
                end
            end
            else if (digit_strobe)
                term <= term * 10 + word_t'(digit_val);
        end
    end

    // sign and magnitude of the final value
    always_ff @(posedge rst)
    begin
        if (op_strobe && op_val == OP_EQU)
        begin
            neg_q <= alu_res[WORD_W-1];
            mag_q <= alu_res[WORD_W-1] ? -alu_res : alu_res;
        end
    end

    // converter is free again in the cycle done is high
    assign conv_accept = start & (~conv_busy | result_valid);

    // keep the sign of the conversion in flight
    always_ff @(posedge rst or posedge clk_100hz)
    begin
        if (clk_100hz)
        begin
            conv_busy <= 1'b0;
            neg_run   <= 1'b0;
            neg_hold  <= 1'b0;
        end
        else
        begin
            if (conv_accept)
            begin
                conv_busy <= 1'b1;
                neg_run   <= neg_q;
            end
            else if (result_valid)
                conv_busy <= 1'b0;
            if (result_valid)
                neg_hold <= neg_run;
        end
    end

    // sign shows together with done
    assign result_neg = result_valid ? neg_run : neg_hold;

    bin_to_bcd conv_i (
        .rst       (rst),
        .clk_100hz (clk_100hz),
        .start     (start),
        .magnitude (mag_q),
        .bcd       (result_bcd),
        .done      (result_valid)
    );

endmodule

/* hw/calculator_top.sv */
`timescale 1ns/1ps

module calculator_top
    import calc_pkg::*;
(
    input  logic                      rst,
    input  logic                      clk_100hz,
    input  logic [NUM_DIGIT_KEYS-1:0] key_digit,
    input  logic [NUM_OP_KEYS-1:0]    key_op,
    output seg_t                      seg,
    output led_t                      led,
    output bcd_t                      result_bcd,
    output logic                      result_neg,
    output logic                      result_valid
);

    logic   digit_strobe;
    digit_t digit_val;
    logic   op_strobe;
    op_t    op_val;

    digit_entry digit_entry_i (
        .rst          (rst),
        .clk_100hz    (clk_100hz),
        .key_digit    (key_digit),
        .digit_strobe (digit_strobe),
        .digit_val    (digit_val),
        .seg          (seg)
    );

    operator_entry operator_entry_i (
        .rst       (rst),
        .clk_100hz (clk_100hz),
        .key_op    (key_op),
        .op_strobe (op_strobe),
        .op_val    (op_val),
        .led       (led)
    );

    // digit and operator paths meet here
    calc_core calc_core_i (
        .rst          (rst),
        .clk_100hz    (clk_100hz),
        .digit_strobe (digit_strobe),
        .digit_val    (digit_val),
        .op_strobe    (op_strobe),
        .op_val       (op_val),
        .result_bcd   (result_bcd),
        .result_neg   (result_neg),
        .result_valid (result_valid)
    );

endmodule

/* sim/tb_calculator.sv */
`timescale 1ns/1ps

module tb_calculator;
    import calc_pkg::*;

    // rst is the clock and clk_100hz the reset of the DUT
    logic                      rst;
    logic                      clk_100hz;
    logic [NUM_DIGIT_KEYS-1:0] key_digit;
    logic [NUM_OP_KEYS-1:0]    key_op;
    seg_t                      seg;
    led_t                      led;
    bcd_t                      result_bcd;
    logic                      result_neg;
    logic                      result_valid;

    string  trace_q[$];
    integer seed = 61239;
    int     mismatch_count = 0;
    int     fail_count = 0;
    int     cycle_count = 0;
    int     cycle_limit = 0;
    bit     load_ok;
    int     i;

    calculator_top dut_i (
        .rst          (rst),
        .clk_100hz    (clk_100hz),
        .key_digit    (key_digit),
        .key_op       (key_op),
        .seg          (seg),
        .led          (led),
        .result_bcd   (result_bcd),
        .result_neg   (result_neg),
        .result_valid (result_valid)
    );

    initial
    begin
        rst = 1'b0;
        forever #20 rst = ~rst;
    end

    always @(posedge rst)
    begin
        cycle_count = cycle_count + 1;
        if (cycle_limit > 0 && cycle_count >= cycle_limit)
        begin
            $display("timeout: run stopped after %0d cycles", cycle_count);
            $display("*** TEST FAILED ***");
            $finish;
        end
    end

    task automatic check_seg(input seg_t expected, input string what);
        if (seg !== expected)
        begin
            mismatch_count++;
            $display("mismatch at %0t: seg %s is %h, expected %h", $time, what, seg, expected);
        end
    endtask

    task automatic check_led(input led_t expected, input string what);
        if (led !== expected)
        begin
            mismatch_count++;
            $display("mismatch at %0t: led %s is %b, expected %b", $time, what, led, expected);
        end
    endtask

    task automatic check_result(input logic neg, input bcd_t expected);
        if (result_neg !== neg || result_bcd !== expected)
        begin
            mismatch_count++;
            $display("mismatch at %0t: result is neg=%b %h, expected neg=%b %h",
                     $time, result_neg, result_bcd, neg, expected);
        end
    endtask

    // 1..9 beat 0, lower number first
    function automatic int priority_digit(input int a, input int b);
        if (a == 0)
            return b;
        if (b == 0)
            return a;
        return (a < b) ? a : b;
    endfunction

    task automatic load_trace(output bit ok);
        int    fd;
        int    n;
        string line;
        fd = $fopen("sim/calculator_trace.txt", "r");
        ok = (fd != 0);
        if (ok)
        begin
            while (!$feof(fd))
            begin
                n = $fgets(line, fd);
                if (n > 0 && line.getc(0) != "#" && line.getc(0) != "\n")
                    trace_q.push_back(line);
            end
            $fclose(fd);
        end
    endtask

    // called and returns 2 ns after a rising edge
    task automatic press_keys(input logic [NUM_DIGIT_KEYS-1:0] digits,
                              input logic [NUM_OP_KEYS-1:0] ops, input int hold);
        key_digit = digits;
        key_op    = ops;
        repeat (hold) @(posedge rst);
        #2;
        key_digit = '0;
        key_op    = '0;
        repeat (3) @(posedge rst);
        #2;
    endtask

    task automatic press_digit(input int d, input int hold);
        logic [NUM_DIGIT_KEYS-1:0] keys;
        keys = '0;
        keys[d] = 1'b1;
        press_keys(keys, '0, hold);
        check_seg(SEG_TABLE[d], $sformatf("after digit %0d", d));
    endtask

    task automatic press_op(input int idx);
        logic [NUM_OP_KEYS-1:0] keys;
        led_t                   expected;
        keys = '0;
        keys[idx] = 1'b1;
        expected = '0;
        expected[idx] = 1'b1;
        press_keys('0, keys, 3);
        check_led(expected, $sformatf("after operator %0d", idx));
    endtask

    task automatic press_random_pair();
        int                        a;
        int                        b;
        logic [NUM_DIGIT_KEYS-1:0] keys;
        a = {$random(seed)} % 10;
        b = a;
        while (b == a)
            b = {$random(seed)} % 10;
        keys = '0;
        keys[a] = 1'b1;
        keys[b] = 1'b1;
        press_keys(keys, '0, 3);
        check_seg(SEG_TABLE[priority_digit(a, b)], $sformatf("after keys %0d+%0d", a, b));
    endtask

    task automatic expect_result(input logic neg, input bcd_t expected);
        int waited;
        bit seen;
        waited = 0;
        seen = 0;
        while (!seen && waited < 60)
        begin
            @(posedge rst);
            #2;
            waited++;
            seen = result_valid;
        end
        if (!seen)
        begin
            fail_count++;
            $display("result_valid never came within 60 cycles at %0t", $time);
        end
        else
            check_result(neg, expected);
    endtask

    task automatic run_step(input string line);
        byte  cmd;
        byte  ch;
        int   pos;
        int   val;
        int   sign;
        bcd_t expected;
        cmd = line.getc(0);
        case (cmd)
            "N":
                for (pos = 1; pos < line.len(); pos++)
                begin
                    ch = line.getc(pos);
                    if (ch >= "0" && ch <= "9")
                        press_digit(int'(ch) - 48, 3);
                end
            "H":
            begin
                void'($sscanf(line.substr(1, line.len() - 1), "%d", val));
                press_digit(val, 10);
            end
            "O":
            begin
                void'($sscanf(line.substr(1, line.len() - 1), "%d", val));
                press_op(val);
            end
            "X":
                press_random_pair();
            "R":
            begin
                void'($sscanf(line.substr(1, line.len() - 1), "%d %h", sign, expected));
                expect_result(sign != 0, expected);
            end
            default:
            begin
                fail_count++;
                $display("unknown trace step: %s", line);
            end
        endcase
    endtask

    initial
    begin
        clk_100hz = 1'b1;
        key_digit = '0;
        key_op    = '0;
        load_trace(load_ok);
        if (!load_ok)
        begin
            fail_count++;
            $display("could not open sim/calculator_trace.txt");
        end
        else
        begin
            cycle_limit = trace_q.size() * 60;
            repeat (5) @(posedge rst);
            #2;
            clk_100hz = 1'b0;
            check_seg('0, "after reset");
            check_led('0, "after reset");
            repeat (4)
            begin
                @(posedge rst);
                #2;
                if (result_valid)
                begin
                    fail_count++;
                    $display("result_valid went high with no calculation at %0t", $time);
                end
            end
            for (i = 0; i < trace_q.size(); i++)
                run_step(trace_q[i]);
        end
        $display("errors: %0d mismatches, %0d other failures", mismatch_count, fail_count);
        if (mismatch_count == 0 && fail_count == 0)
            $display("*** TEST PASSED ***");
        else
            $display("*** TEST FAILED ***");
        $finish;
    end

endmodule

/* sim/calculator_trace.txt */
# N <digits> press each digit, H <d> hold a digit 10 cycles, O <0..4> add sub mul div equ
# X press a random pair of digit keys, R <neg> <ten bcd digits> expected result
N 123
O 0
N 45
O 4
R 0 0000000168
N 70
O 1
N 95
O 1
N 4
O 4
R 1 0000000029
N 50000
O 2
N 50000
O 4
R 1 1794967296
O 1
N 7
O 3
N 2
O 4
R 1 0000000003
H 4
N 2
O 4
R 0 0000000042
X
O 3
N 0
O 4
R 0 0000000000

/* calculator.f */
hw/calc_pkg.sv
hw/key_capture.sv
hw/bin_to_bcd.sv
hw/digit_entry.sv
hw/operator_entry.sv
hw/calc_core.sv
hw/calculator_top.sv
sim/tb_calculator.sv

/* Makefile */
TOP = tb_calculator

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing -j 0 --top-module $(TOP) -Mdir obj_dir -f calculator.f

run: compile
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -q -F '*** TEST PASSED ***'

clean:
	rm -rf obj_dir
